// ==== hdl/rv32f_decode.sv ====
`timescale 1ns/1ps

module rv32f_decode import rv32f_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            insn_valid,
  input  word_t           insn,
  output logic            claim,
  output decode_execute_t idex
);

  fpu_insn_t   fi;
  funct7_t     f7;
  logic [15:0] unclaimed_cnt;  // illegal traffic seen, probed from sim

  assign fi = fpu_insn_t'(insn);
  assign f7 = {fi.offset_funct5, fi.offset_fmt};

  // dispatch on the real opcode, then funct7 for op-fp
  always_comb begin
    idex    = '0;
    idex.op = OP_NONE;
    case (fi.opcode)
      FPU_OPCODE_LD: begin
        idex.op  = OP_LOAD;
        idex.imm = {fi.offset_funct5, fi.offset_fmt, fi.offset_rs2}; // i-type imm
        idex.rs1 = fi.rs1;        // integer base, value comes from host
        idex.rd  = fi.rd_offset;
      end
      FPU_OPCODE_SW: begin
        idex.op  = OP_STORE;
        idex.imm = {fi.offset_funct5, fi.offset_fmt, fi.rd_offset}; // s-type split imm
        idex.rs1 = fi.rs1;
        idex.rs2 = fi.offset_rs2; // float source
      end
      FPU_OPCODE_ARI: begin
        case (f7)
          F7_ADD:  idex.op = OP_ADD;
          F7_SUB:  idex.op = OP_SUB;
          F7_MUL:  idex.op = OP_MUL;
          F7_SGNJ: idex.op = OP_SGNJ;
          default: idex.op = OP_NONE;  // div, sqrt, cvt etc not handled
        endcase
        idex.funct7 = f7;
        idex.frm    = fi.width_rm;     // rtz forced, only sgnj looks at it
        idex.rs1    = fi.rs1;
        idex.rs2    = fi.offset_rs2;
        idex.rd     = fi.rd_offset;
      end
      default: idex.op = OP_NONE;
    endcase
    idex.start = insn_valid && (idex.op != OP_NONE);
  end

  assign claim = idex.start;

  // count strobes nobody took
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      unclaimed_cnt <= '0;
    end else if (insn_valid && !claim) begin
      unclaimed_cnt <= unclaimed_cnt + 16'd1;
    end
  end

endmodule

// ==== hdl/rv32f_execute.sv ====
`timescale 1ns/1ps

module rv32f_execute import rv32f_pkg::*; #(
  parameter int MEM_ADDR_BITS = 32
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     insn_valid,
  input  logic                     claim,
  input  decode_execute_t          idex,
  input  word_t                    int_rs1,
  output freg_idx_t                raddr_a,
  output freg_idx_t                raddr_b,
  input  word_t                    rdata_a,
  input  word_t                    rdata_b,
  output logic                     add_go,
  output logic                     mul_go,
  output logic                     sub,
  input  word_t                    add_result,
  input  word_t                    mul_result,
  output logic                     rf_we,
  output freg_idx_t                rf_waddr,
  output word_t                    rf_wdata,
  output logic                     busy,
  output logic                     done,
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [MEM_ADDR_BITS-1:0] mem_addr,
  output word_t                    mem_wdata,
  input  logic                     mem_ack,
  input  word_t                    mem_rdata
);

  exec_state_e     state, state_nx;
  decode_execute_t ex;        // instruction in flight
  word_t           eff_addr;  // int rs1 + sext(imm)
  logic            issue;
  logic            sgn;
  word_t           sgnj_res;

  assign issue = (state == ST_IDLE) && insn_valid && claim;

  always_comb begin
    state_nx = state;
    case (state)
      ST_IDLE:  if (issue) begin
        state_nx = (idex.op == OP_LOAD || idex.op == OP_STORE) ? ST_MEM : ST_ARITH;
      end
      ST_ARITH: state_nx = ST_WB;               // units register this edge
      ST_MEM:   if (mem_ack) state_nx = ST_IDLE; // ack may be same cycle
      ST_WB:    state_nx = ST_IDLE;
      default:  state_nx = ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nx;
      done  <= (state == ST_WB) || (state == ST_MEM && mem_ack);  // retire pulse
    end
  end

  // payload capture at issue
  always_ff @(posedge CLK) begin
    if (issue) begin
      ex       <= idex;
      eff_addr <= int_rs1 + {{20{idex.imm[11]}}, idex.imm};
    end
  end

  assign raddr_a = ex.rs1;
  assign raddr_b = ex.rs2;   // also store data

  assign add_go = (state == ST_ARITH) && (ex.op == OP_ADD || ex.op == OP_SUB);
  assign mul_go = (state == ST_ARITH) && (ex.op == OP_MUL);
  assign sub    = (ex.op == OP_SUB);

  // sign injection, magnitude always from rs1
  always_comb begin
    case (ex.frm)
      3'b001:  sgn = ~rdata_b[31];             // fsgnjn
      3'b010:  sgn = rdata_a[31] ^ rdata_b[31]; // fsgnjx
      default: sgn = rdata_b[31];              // fsgnj
    endcase
    sgnj_res = {sgn, rdata_a[30:0]};
  end

  // writeback select
  assign rf_we    = (state == ST_WB) || (state == ST_MEM && mem_ack && ex.op == OP_LOAD);
  assign rf_waddr = ex.rd;
  always_comb begin
    case (ex.op)
      OP_LOAD:        rf_wdata = mem_rdata;
      OP_ADD, OP_SUB: rf_wdata = add_result;
      OP_MUL:         rf_wdata = mul_result;
      default:        rf_wdata = sgnj_res;
    endcase
  end

  assign busy = (state != ST_IDLE);

  // memory side, all held from latched state while req is up
  assign mem_req   = (state == ST_MEM);
  assign mem_we    = (state == ST_MEM) && (ex.op == OP_STORE);
  assign mem_addr  = eff_addr[MEM_ADDR_BITS-1:0];
  assign mem_wdata = rdata_b;

endmodule

// ==== hdl/rv32f_ext.sv ====
`timescale 1ns/1ps

module rv32f_ext import rv32f_pkg::*; #(
  parameter int MEM_ADDR_BITS = 32
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  // host side
  input  logic                     insn_valid,
  input  word_t                    insn,
  input  word_t                    int_rs1,
  output logic                     claim,
  output logic                     busy,
  output logic                     done,
  // data memory
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [MEM_ADDR_BITS-1:0] mem_addr,
  output word_t                    mem_wdata,
  input  logic                     mem_ack,
  input  word_t                    mem_rdata
);

  decode_execute_t idex;
  freg_idx_t       raddr_a, raddr_b, rf_waddr;
  word_t           rdata_a, rdata_b, rf_wdata;
  word_t           add_result, mul_result;
  logic            rf_we;
  logic            add_go, mul_go, sub;

  rv32f_decode u_decode (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .insn_valid (insn_valid),
    .insn       (insn),
    .claim      (claim),
    .idex       (idex)
  );

  // operands go straight from the read ports to both units
  rv32f_regfile u_regfile (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .raddr_a (raddr_a),
    .raddr_b (raddr_b),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b),
    .we      (rf_we),
    .waddr   (rf_waddr),
    .wdata   (rf_wdata)
  );

  rv32f_execute #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_execute (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .insn_valid (insn_valid),
    .claim      (claim),
    .idex       (idex),
    .int_rs1    (int_rs1),
    .raddr_a    (raddr_a),
    .raddr_b    (raddr_b),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .add_go     (add_go),
    .mul_go     (mul_go),
    .sub        (sub),
    .add_result (add_result),
    .mul_result (mul_result),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .busy       (busy),
    .done       (done),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  rv32f_fpu_addsub u_addsub (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .go     (add_go),
    .sub    (sub),
    .a      (rdata_a),
    .b      (rdata_b),
    .result (add_result)
  );

  rv32f_fpu_mul u_mul (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .go     (mul_go),
    .a      (rdata_a),
    .b      (rdata_b),
    .result (mul_result)
  );

endmodule

// ==== hdl/rv32f_fpu_addsub.sv ====
`timescale 1ns/1ps

module rv32f_fpu_addsub import rv32f_pkg::*; (
  input  logic  CLK,
  input  logic  rst_n,
  input  logic  go,
  input  logic  sub,
  input  word_t a,
  input  word_t b,
  output word_t result
);

  fp_parts_t        fa, fb;          // unpacked, subnormals flushed
  fp_parts_t        big, lesser;     // ordered by magnitude
  logic [23:0]      sig_big, sig_small;
  logic [26:0]      ext_small;       // significand + guard, round, sticky
  logic [26:0]      aligned;
  logic [26:0]      lost_mask;
  fexp_t            diff;
  logic             eff_sub;
  logic [27:0]      sum;             // one carry bit on top
  logic [26:0]      norm;
  logic [4:0]       lz;
  logic signed [9:0] res_exp;
  word_t            res_next;

  // unpack, sub just flips the sign of b
  always_comb begin
    fa = fp_parts_t'(a);
    fb = fp_parts_t'({b[31] ^ sub, b[30:0]});
    if (fa.exp == '0) fa.mant = '0;  // subnormal reads as signed zero
    if (fb.exp == '0) fb.mant = '0;
  end

  // swap so big holds the larger magnitude
  always_comb begin
    if ({fb.exp, fb.mant} > {fa.exp, fa.mant}) begin
      big    = fb;
      lesser = fa;
    end else begin
      big    = fa;
      lesser = fb;
    end
  end

  assign eff_sub   = fa.sign ^ fb.sign;
  assign diff      = big.exp - lesser.exp;
  assign sig_big   = {|big.exp, big.mant};     // hidden bit
  assign sig_small = {|lesser.exp, lesser.mant};
  assign ext_small = {sig_small, 3'b000};

  // alignment shift, everything shifted out folds into sticky
  always_comb begin
    lost_mask = (27'd1 << diff[4:0]) - 27'd1;
    if (diff >= 8'd27) begin
      aligned = {26'b0, |ext_small};
    end else begin
      aligned    = ext_small >> diff[4:0];
      aligned[0] = aligned[0] | (|(ext_small & lost_mask));
    end
  end

  assign sum = eff_sub ? {1'b0, sig_big, 3'b000} - {1'b0, aligned}
                       : {1'b0, sig_big, 3'b000} + {1'b0, aligned};

  // leading one search, highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < 27; i++) begin
      if (sum[i]) lz = 5'(26 - i);
    end
  end

  // normalize so norm[26] is the hidden bit
  always_comb begin
    if (sum[27]) begin
      norm    = sum[27:1];  // carry out, shift right one
      res_exp = $signed({2'b00, big.exp}) + 10'sd1;
    end else begin
      norm    = sum[26:0] << lz;
      res_exp = $signed({2'b00, big.exp}) - $signed({5'b00000, lz});
    end
  end

  // truncate then flush or saturate
  always_comb begin
    if (sum == '0) begin
      res_next = {(eff_sub ? 1'b0 : big.sign), 31'b0};  // exact cancel is +0
    end else if (res_exp <= 10'sd0) begin
      res_next = {big.sign, 31'b0};
    end else if (res_exp >= 10'sd255) begin
      res_next = {big.sign, 8'hfe, 23'h7fffff};          // max finite
    end else begin
      res_next = {big.sign, res_exp[7:0], norm[25:3]};
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (go) begin
      result <= res_next;
    end
  end

endmodule

// ==== hdl/rv32f_fpu_mul.sv ====
`timescale 1ns/1ps

module rv32f_fpu_mul import rv32f_pkg::*; (
  input  logic  CLK,
  input  logic  rst_n,
  input  logic  go,
  input  word_t a,
  input  word_t b,
  output word_t result
);

  fp_parts_t         pa, pb;
  logic [23:0]       sig_a, sig_b;
  logic [47:0]       prod;        // 1.x * 1.x lands in [1,4)
  logic              sign;
  logic              is_zero;
  fmant_t            mant;
  logic signed [9:0] res_exp;
  word_t             res_next;

  assign pa = fp_parts_t'(a);
  assign pb = fp_parts_t'(b);

  // subnormals drop to zero through the hidden bit
  assign sig_a   = (pa.exp == '0) ? 24'd0 : {1'b1, pa.mant};
  assign sig_b   = (pb.exp == '0) ? 24'd0 : {1'b1, pb.mant};
  assign is_zero = (pa.exp == '0) || (pb.exp == '0);
  assign sign    = pa.sign ^ pb.sign;
  assign prod    = sig_a * sig_b;

  // one step normalize, low bits just truncated
  always_comb begin
    res_exp = $signed({2'b00, pa.exp}) + $signed({2'b00, pb.exp}) - 10'sd127;
    if (prod[47]) begin
      mant    = prod[46:24];
      res_exp = res_exp + 10'sd1;
    end else begin
      mant    = prod[45:23];
    end
  end

  always_comb begin
    if (is_zero || res_exp <= 10'sd0) begin
      res_next = {sign, 31'b0};              // zero operand or underflow
    end else if (res_exp >= 10'sd255) begin
      res_next = {sign, 8'hfe, 23'h7fffff};  // saturate
    end else begin
      res_next = {sign, res_exp[7:0], mant};
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (go) begin
      result <= res_next;
    end
  end

endmodule

// ==== hdl/rv32f_pkg.sv ====
package rv32f_pkg;

  // plain vector types
  typedef logic [31:0] word_t;      // data word or byte address
  typedef logic [4:0]  freg_idx_t;  // f0..f31
  typedef logic [6:0]  funct7_t;
  typedef logic [2:0]  rm_t;        // frm on arithmetic, width on ld/st
  typedef logic [7:0]  fexp_t;      // biased exponent
  typedef logic [22:0] fmant_t;     // stored fraction, hidden bit not included

  // major opcodes of the F extension subset
  typedef enum logic [6:0] {
    FPU_OPCODE_LD  = 7'b0000111,   // flw
    FPU_OPCODE_SW  = 7'b0100111,   // fsw
    FPU_OPCODE_ARI = 7'b1010011    // op-fp
  } fpu_opcode_e;

  // internal operation class, picked by decode
  typedef enum logic [2:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE,
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_SGNJ
  } fpu_op_e;

  // funct7 values, fmt bits = 00 for single
  localparam funct7_t F7_ADD  = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0000100;
  localparam funct7_t F7_MUL  = 7'b0001000;
  localparam funct7_t F7_SGNJ = 7'b0010000;

  // raw instruction, field names follow the r-type / s-type overlap
  typedef struct packed {
    logic [4:0] offset_funct5;
    logic [1:0] offset_fmt;
    freg_idx_t  offset_rs2;
    freg_idx_t  rs1;
    rm_t        width_rm;
    freg_idx_t  rd_offset;
    logic [6:0] opcode;
  } fpu_insn_t;

  // decode to execute
  typedef struct packed {
    logic        start;   // valid and claimed
    fpu_op_e     op;
    funct7_t     funct7;
    rm_t         frm;     // sign-injection select on OP_SGNJ
    freg_idx_t   rs1;
    freg_idx_t   rs2;
    freg_idx_t   rd;
    logic [11:0] imm;     // ld/st offset, sign extended in execute
  } decode_execute_t;

  typedef struct packed {
    logic   sign;
    fexp_t  exp;
    fmant_t mant;
  } fp_parts_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARITH,
    ST_MEM,
    ST_WB
  } exec_state_e;

endpackage

// ==== hdl/rv32f_regfile.sv ====
`timescale 1ns/1ps

module rv32f_regfile import rv32f_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  freg_idx_t raddr_a,
  input  freg_idx_t raddr_b,
  output word_t     rdata_a,
  output word_t     rdata_b,
  input  logic      we,
  input  freg_idx_t waddr,
  input  word_t     wdata
);

  word_t regs [32];  // f0 is an ordinary register here

  // write port, whole file clears on reset
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // async reads, no write bypass
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

// ==== run.sh ====
#!/bin/sh
# build the float extension testbench with verilator and run it
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv32f_ext_tb \
  -Mdir obj_dir -o rv32f_ext_sim \
  -f rv32f_ext.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/rv32f_ext_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

// ==== rv32f_ext.f ====
hdl/rv32f_pkg.sv
hdl/rv32f_decode.sv
hdl/rv32f_regfile.sv
hdl/rv32f_fpu_addsub.sv
hdl/rv32f_fpu_mul.sv
hdl/rv32f_execute.sv
hdl/rv32f_ext.sv
test/rv32f_ext_checker.sv
test/rv32f_ext_tb.sv

// ==== test/rv32f_ext_checker.sv ====
`timescale 1ns/1ps

module rv32f_ext_checker import rv32f_pkg::*; #(
  parameter int MEM_ADDR_BITS = 32
) (
  input logic                     CLK,
  input logic                     rst_n,
  input logic                     insn_valid,
  input logic                     claim,
  input logic                     busy,
  input logic                     done,
  input logic                     mem_req,
  input logic                     mem_we,
  input logic                     mem_ack,
  input logic [MEM_ADDR_BITS-1:0] mem_addr,
  input word_t                    mem_wdata
);

  // retire is a single pulse
  done_pulse: assert property (@(posedge CLK) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // memory traffic only from a busy unit
  req_busy: assert property (@(posedge CLK) disable iff (!rst_n) $rose(mem_req) |-> busy)
    else $error("mem_req rose while busy was low");

  // request and payload held until ack
  req_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we)
                            && $stable(mem_wdata))
    else $error("memory request changed before ack");

  claim_valid: assert property (@(posedge CLK) disable iff (!rst_n) claim |-> insn_valid)
    else $error("claim high without insn_valid");

endmodule

bind rv32f_ext rv32f_ext_checker #(
  .MEM_ADDR_BITS (MEM_ADDR_BITS)
) u_checker (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .insn_valid (insn_valid),
  .claim      (claim),
  .busy       (busy),
  .done       (done),
  .mem_req    (mem_req),
  .mem_we     (mem_we),
  .mem_ack    (mem_ack),
  .mem_addr   (mem_addr),
  .mem_wdata  (mem_wdata)
);

// ==== test/rv32f_ext_tb.sv ====
`timescale 1ns/1ps

module rv32f_ext_tb import rv32f_pkg::*; ();

  localparam int    TIMEOUT   = 200;            // cycles allowed per instruction
  localparam int    ARITH_LAT = 2;              // edges after the issue edge until done
  localparam word_t MAX_FIN   = 32'h7f7f_ffff;  // largest finite single

  logic  clk, rst_n;
  logic  insn_valid, claim, busy, done;
  word_t insn, int_rs1;
  logic  mem_req, mem_we, mem_ack;
  word_t mem_addr, mem_wdata, mem_rdata;

  integer seed = 32'h2267_558b;
  word_t  mem [word_t];     // sparse data memory
  word_t  shadow [32];      // expected float registers
  word_t  exp_addr_q [$];   // stores not yet seen on the bus
  word_t  exp_data_q [$];

  rv32f_ext #(
    .MEM_ADDR_BITS (32)
  ) u_dut (
    .CLK        (clk),
    .rst_n      (rst_n),
    .insn_valid (insn_valid),
    .insn       (insn),
    .int_rs1    (int_rs1),
    .claim      (claim),
    .busy       (busy),
    .done       (done),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("ERROR: %s got %h expected %h", name, got, want);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // untouched words, every address bit matters
  function automatic word_t fill_word(input word_t a);
    return {a[15:0], ~a[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic word_t mem_read(input word_t a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  // exact sum truncated toward zero, b already carries its final sign
  function automatic word_t fp_add_rtz(input word_t a, input word_t b);
    word_t        x, y, t;
    logic [127:0] big, lesser, lost, r;
    int           e_big, e_small, d, msb, e_res;
    x = (a[30:23] == 8'd0) ? {a[31], 31'b0} : a;  // subnormal in, signed zero
    y = (b[30:23] == 8'd0) ? {b[31], 31'b0} : b;
    if (y[30:0] > x[30:0]) begin
      t = x;
      x = y;
      y = t;
    end
    e_big   = int'(x[30:23]);
    e_small = int'(y[30:23]);
    big     = (e_big == 0) ? '0 : 128'({1'b1, x[22:0]}) << 64;  // 64 spare low bits
    lesser  = (e_small == 0) ? '0 : 128'({1'b1, y[22:0]}) << 64;
    d       = e_big - e_small;
    if (d > 100) begin
      lesser = {127'b0, |lesser};
    end else begin
      lost   = lesser & ((128'd1 << d) - 128'd1);
      lesser = (lesser >> d) | {127'b0, |lost};  // anything lost only nudges the lsb
    end
    r = (x[31] == y[31]) ? big + lesser : big - lesser;
    if (r == '0) begin
      return {(x[31] == y[31]) ? x[31] : 1'b0, 31'b0};  // cancel gives +0
    end
    msb = 0;
    for (int i = 0; i < 128; i++) begin
      if (r[i]) msb = i;
    end
    e_res = e_big + msb - 87;  // hidden bit of big sits at 87
    if (e_res <= 0) return {x[31], 31'b0};
    if (e_res >= 255) return {x[31], MAX_FIN[30:0]};
    r = r >> (msb - 23);
    return {x[31], e_res[7:0], r[22:0]};
  endfunction

  function automatic word_t fp_mul_rtz(input word_t a, input word_t b);
    logic [63:0] p;
    logic        s;
    int          e, msb;
    s = a[31] ^ b[31];
    if (a[30:23] == 8'd0 || b[30:23] == 8'd0) return {s, 31'b0};
    p   = 64'({1'b1, a[22:0]}) * 64'({1'b1, b[22:0]});
    msb = 0;
    for (int i = 0; i < 64; i++) begin
      if (p[i]) msb = i;
    end
    // binary point of the product between bits 46 and 45
    e = int'(a[30:23]) + int'(b[30:23]) - 127 + (msb - 46);
    if (e <= 0) return {s, 31'b0};
    if (e >= 255) return {s, MAX_FIN[30:0]};
    p = p >> (msb - 23);
    return {s, e[7:0], p[22:0]};
  endfunction

  function automatic word_t sign_inject(input word_t a, input word_t b, input rm_t rm);
    case (rm)
      3'b000:  return {b[31], a[30:0]};
      3'b001:  return {~b[31], a[30:0]};
      default: return {a[31] ^ b[31], a[30:0]};
    endcase
  endfunction

  function automatic word_t flw_word(input freg_idx_t rd, input logic [11:0] imm);
    return {imm, 5'd1, 3'b010, rd, 7'b0000111};
  endfunction

  function automatic word_t fsw_word(input freg_idx_t rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd1, 3'b010, imm[4:0], 7'b0100111};
  endfunction

  function automatic word_t opfp_word(input funct7_t f7, input freg_idx_t rs2,
                                      input freg_idx_t rs1, input rm_t rm,
                                      input freg_idx_t rd);
    return {f7, rs2, rs1, rm, rd, 7'b1010011};
  endfunction

  function automatic word_t rand_float(input int lo, input int span);
    word_t w;
    w         = $random(seed);
    w[30:23]  = 8'(lo + (($random(seed) & 32'h7fff_ffff) % span));
    return w;
  endfunction

  function automatic word_t rand_addr();
    return word_t'($random(seed)) & 32'hffff_fffc;
  endfunction

  // memory model, ack 0..3 cycles after the request, compares every store
  initial begin : mem_model
    int   delay;
    logic pending;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    pending   = 1'b0;
    delay     = 0;
    forever begin
      @(negedge clk);
      mem_ack = 1'b0;
      if (rst_n && mem_req) begin
        if (!pending) begin
          pending = 1'b1;
          delay   = $random(seed) & 3;
        end
        if (delay == 0) begin
          mem_ack = 1'b1;
          pending = 1'b0;
          if (mem_we) begin
            if (exp_addr_q.size() == 0) begin
              $display("store to %h that no fsw asked for", mem_addr);
              $display("Regression failed");
              $fatal(1, "stray store");
            end
            check("mem_addr", mem_addr, exp_addr_q.pop_front());
            check("mem_wdata", mem_wdata, exp_data_q.pop_front());
            mem[mem_addr] = mem_wdata;
          end else begin
            mem_rdata = mem_read(mem_addr);
          end
        end else begin
          delay--;
        end
      end
    end
  end

  // one instruction, lat counts edges from the issue edge to the done cycle
  task automatic run_insn(input word_t i, input word_t base, input logic want, output int lat);
    int n;
    @(negedge clk);
    insn       = i;
    int_rs1    = base;
    insn_valid = 1'b1;
    #1;
    check("claim", {31'b0, claim}, {31'b0, want});
    @(posedge clk);
    @(negedge clk);
    insn_valid = 1'b0;
    insn       = $random(seed);  // junk while idle
    check("busy", {31'b0, busy}, {31'b0, want});
    n = 0;
    if (want) begin
      while (!done && n < TIMEOUT) begin
        @(posedge clk);
        @(negedge clk);
        n++;
      end
      if (!done) begin
        $display("no done within %0d cycles for instruction %h", TIMEOUT, i);
        $display("Regression failed");
        $fatal(1, "timeout");
      end
    end
    lat = n;
  endtask

  task automatic load_reg(input freg_idx_t rd, input word_t addr);
    logic [11:0] off;
    int          lat;
    off = 12'($random(seed));
    run_insn(flw_word(rd, off), addr - {{20{off[11]}}, off}, 1'b1, lat);
    shadow[rd] = mem_read(addr);
  endtask

  task automatic set_reg(input freg_idx_t rd, input word_t val);
    word_t addr;
    addr       = rand_addr();
    mem[addr]  = val;
    load_reg(rd, addr);
  endtask

  task automatic store_reg(input freg_idx_t rs2, input word_t addr);
    logic [11:0] off;
    int          lat;
    off = 12'($random(seed));
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(shadow[rs2]);
    run_insn(fsw_word(rs2, off), addr - {{20{off[11]}}, off}, 1'b1, lat);
    check("stores pending", exp_addr_q.size(), 32'd0);
  endtask

  // two operands in, one op, result out through a store
  task automatic fp_case(input funct7_t f7, input rm_t rm, input word_t a, input word_t b);
    freg_idx_t ra, rb, rd;
    word_t     r;
    int        lat;
    ra = freg_idx_t'($random(seed));
    rb = ra + 5'd7;
    rd = freg_idx_t'($random(seed));
    set_reg(ra, a);
    set_reg(rb, b);
    case (f7)
      F7_ADD:  r = fp_add_rtz(a, b);
      F7_SUB:  r = fp_add_rtz(a, {~b[31], b[30:0]});
      F7_MUL:  r = fp_mul_rtz(a, b);
      default: r = sign_inject(a, b, rm);
    endcase
    run_insn(opfp_word(f7, rb, ra, rm, rd), $random(seed), 1'b1, lat);
    check("done latency", lat, ARITH_LAT);
    shadow[rd] = r;
    store_reg(rd, rand_addr());
  endtask

  initial begin
    freg_idx_t r;
    word_t     x;
    int        lat;
    insn_valid = 1'b0;
    insn       = '0;
    int_rs1    = '0;
    rst_n      = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check("busy", {31'b0, busy}, 32'd0);
    check("done", {31'b0, done}, 32'd0);
    check("mem_req", {31'b0, mem_req}, 32'd0);
    store_reg(5'd9, rand_addr());  // regfile clear after reset

    // flw then fsw of fill pattern words
    for (int k = 0; k < 8; k++) begin
      r = freg_idx_t'($random(seed));
      load_reg(r, rand_addr());
      store_reg(r, rand_addr());
    end

    for (int k = 0; k < 12; k++) begin
      fp_case(F7_ADD, 3'b001, rand_float(120, 16), rand_float(120, 16));
      fp_case(F7_SUB, 3'b001, rand_float(120, 16), rand_float(120, 16));
    end
    x = rand_float(110, 30);
    fp_case(F7_SUB, 3'b001, x, x);                           // exact cancel
    fp_case(F7_ADD, 3'b001, x, {~x[31], x[30:0]});
    fp_case(F7_ADD, 3'b001, 32'h8000_1234, x);               // subnormal operand
    fp_case(F7_SUB, 3'b001, 32'h0080_0001, 32'h0080_0000);   // result below normal
    fp_case(F7_SUB, 3'b001, 32'h4f00_0000, 32'h3000_0001);   // far smaller operand
    fp_case(F7_ADD, 3'b001, MAX_FIN, MAX_FIN);               // saturate

    for (int k = 0; k < 10; k++) begin
      fp_case(F7_MUL, 3'b001, rand_float(100, 56), rand_float(100, 56));
    end
    fp_case(F7_MUL, 3'b001, 32'h1f80_0000, 32'h9f80_0000);   // underflow
    fp_case(F7_MUL, 3'b001, 32'h7e80_0000, 32'hfe80_0000);   // overflow
    fp_case(F7_MUL, 3'b001, 32'h0000_0042, x);               // subnormal times normal

    for (int k = 0; k < 4; k++) begin
      fp_case(F7_SGNJ, 3'b000, rand_float(1, 254), rand_float(1, 254));
      fp_case(F7_SGNJ, 3'b001, rand_float(1, 254), rand_float(1, 254));
      fp_case(F7_SGNJ, 3'b010, rand_float(1, 254), rand_float(1, 254));
    end

    // rejected ops must leave f12 alone
    r = 5'd12;
    set_reg(r, 32'h4049_0fdb);
    run_insn(opfp_word(7'b0001100, 5'd1, 5'd2, 3'b001, r), '0, 1'b0, lat);  // fdiv.s
    run_insn(opfp_word(7'b0101100, 5'd0, 5'd2, 3'b001, r), '0, 1'b0, lat);  // fsqrt.s
    run_insn(opfp_word(7'b0000001, 5'd1, 5'd2, 3'b001, r), '0, 1'b0, lat);  // fadd.d
    run_insn(opfp_word(7'b1110000, 5'd0, 5'd2, 3'b000, r), '0, 1'b0, lat);  // fmv.x.w
    run_insn({7'b0, 5'd1, 5'd2, 3'b000, r, 7'b0110011}, '0, 1'b0, lat);      // integer add
    check("unclaimed_cnt", {16'b0, u_dut.u_decode.unclaimed_cnt}, 32'd5);  // five turned away
    store_reg(r, rand_addr());

    $display("Regression passed");
    $finish;
  end

endmodule
